//--- branchCompare.sv
`timescale 1ns/100ps

module branchCompare (
    input  mipsPkg::instrT instr,
    input  logic [31:0]    opA,
    input  logic [31:0]    opB,
    output logic           cond
);
    import mipsPkg::*;

    logic aNeg;
    logic aZero;
    logic bZero;

    assign aNeg  = opA[31];
    assign aZero = (opA == 32'd0);
    assign bZero = (opB == 32'd0);

    always_comb begin
        case (instr)
            BEQ:            cond = (opA == opB);
            BNE:            cond = (opA != opB);
            // Sign tests look only at rs
            BGEZ, BGEZAL:   cond = !aNeg;
            BGTZ:           cond = !aNeg && !aZero;
            BLEZ:           cond = aNeg || aZero;
            BLTZ, BLTZAL:   cond = aNeg;
            // Conditional moves test rt
            MOVZ:           cond = bZero;
            MOVN:           cond = !bZero;
            default:        cond = 1'b0;
        endcase
    end

endmodule

//--- files.f
mipsPkg.sv
regFile.sv
instrDecoder.sv
branchCompare.sv
idStage.sv
idTop.sv
idTop_checker.sv
idTop_tb.sv

//--- idStage.sv
`timescale 1ns/100ps

module idStage (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           clr,
    input  logic [31:0]    code,
    input  logic [31:0]    pc,
    input  logic [4:0]     fwdAddrEx,
    input  logic [4:0]     fwdAddrMem,
    input  logic [31:0]    fwdDataEx,
    input  logic [31:0]    fwdDataMem,
    output logic [4:0]     raddr1,
    output logic [4:0]     raddr2,
    input  logic [31:0]    rdata1,
    input  logic [31:0]    rdata2,
    output mipsPkg::instrT instr,
    output logic           cmp,
    output logic [25:0]    jumpTarget,
    output logic [31:0]    jumpReg,
    output mipsPkg::instrT instrEx,
    output logic [31:0]    pcEx,
    output logic [31:0]    dataRsEx,
    output logic [31:0]    dataRtEx,
    output logic [31:0]    wbDataEx,
    output logic [15:0]    imm16Ex,
    output logic [4:0]     shamtEx,
    output logic [4:0]     addrRsEx,
    output logic [4:0]     addrRtEx,
    output logic [4:0]     addrRdEx,
    output logic [4:0]     wbAddrEx,
    output logic           excRiEx
);
    import mipsPkg::*;

    instrClassT  instrClass;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [15:0] imm16;
    logic        excRi;
    logic [31:0] opRs;
    logic [31:0] opRt;
    logic        isLink;
    logic        isMove;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;

    instrDecoder u_decoder (
        .code       (code),
        .instr      (instr),
        .instrClass (instrClass),
        .rs         (rs),
        .rt         (rt),
        .rd         (rd),
        .shamt      (shamt),
        .imm16      (imm16),
        .jumpTarget (jumpTarget),
        .excRi      (excRi)
    );

    assign raddr1 = rs;
    assign raddr2 = rt;

    // Youngest result first, register zero is never forwarded
    function automatic logic [31:0] pickOperand(input logic [4:0] addr,
                                                input logic [31:0] regData);
        if (fwdAddrEx == addr && fwdAddrEx != 5'd0) begin
            return fwdDataEx;
        end else if (fwdAddrMem == addr && fwdAddrMem != 5'd0) begin
            return fwdDataMem;
        end
        return regData;
    endfunction

    always_comb begin
        opRs = pickOperand(rs, rdata1);
    end

    always_comb begin
        opRt = pickOperand(rt, rdata2);
    end

    branchCompare u_compare (
        .instr (instr),
        .opA   (opRs),
        .opB   (opRt),
        .cond  (cmp)
    );

    assign jumpReg = opRs;

    assign isLink = (instr == JAL) || (instr == JALR) ||
                    (instr == BGEZAL) || (instr == BLTZAL);
    assign isMove = (instr == MOVZ) || (instr == MOVN);

    // Early write-back target
    always_comb begin
        if (instr == JAL) begin
            wbAddr = LINK_REG;
        end else if (instr == BGEZAL || instr == BLTZAL) begin
            wbAddr = cmp ? LINK_REG : 5'd0;
        end else if (isMove) begin
            wbAddr = cmp ? rd : 5'd0;
        end else if (instrClass == CALC_R || instr == JALR ||
                     instr == MFHI || instr == MFLO) begin
            wbAddr = rd;
        end else if (instrClass == CALC_I || instrClass == MEM_READ || instr == MFC0) begin
            wbAddr = rt;
        end else begin
            wbAddr = 5'd0;
        end
    end

    // No data travels with a write to register zero
    always_comb begin
        if (wbAddr == 5'd0) begin
            wbData = 32'd0;
        end else if (isMove) begin
            wbData = opRs;
        end else if (isLink) begin
            wbData = pc + PC_LINK_OFFSET;
        end else if (instr == LUI) begin
            wbData = {imm16, 16'h0000};
        end else begin
            wbData = 32'd0;
        end
    end

    // Decode to execute register
    always_ff @(posedge clk) begin
        if (rst || clr) begin
            instrEx  <= NOP;
            pcEx     <= 32'd0;
            dataRsEx <= 32'd0;
            dataRtEx <= 32'd0;
            wbDataEx <= 32'd0;
            imm16Ex  <= 16'd0;
            shamtEx  <= 5'd0;
            addrRsEx <= 5'd0;
            addrRtEx <= 5'd0;
            addrRdEx <= 5'd0;
            wbAddrEx <= 5'd0;
            excRiEx  <= 1'b0;
        end else if (!stall) begin
            instrEx  <= instr;
            pcEx     <= pc;
            dataRsEx <= opRs;
            dataRtEx <= opRt;
            wbDataEx <= wbData;
            imm16Ex  <= imm16;
            shamtEx  <= shamt;
            addrRsEx <= rs;
            addrRtEx <= rt;
            addrRdEx <= rd;
            wbAddrEx <= wbAddr;
            excRiEx  <= excRi;
        end
    end

endmodule

//--- idTop.sv
`timescale 1ns/100ps

module idTop (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           clr,
    input  logic [31:0]    code,
    input  logic [31:0]    pc,
    input  logic [4:0]     fwdAddrEx,
    input  logic [31:0]    fwdDataEx,
    input  logic [4:0]     fwdAddrMem,
    input  logic [31:0]    fwdDataMem,
    input  logic           wbEn,
    input  logic [4:0]     wbAddr,
    input  logic [31:0]    wbData,
    output mipsPkg::instrT instr,
    output logic           cmp,
    output logic [25:0]    jumpTarget,
    output logic [31:0]    jumpReg,
    output mipsPkg::instrT instrEx,
    output logic [31:0]    pcEx,
    output logic [31:0]    dataRsEx,
    output logic [31:0]    dataRtEx,
    output logic [31:0]    wbDataEx,
    output logic [15:0]    imm16Ex,
    output logic [4:0]     shamtEx,
    output logic [4:0]     addrRsEx,
    output logic [4:0]     addrRtEx,
    output logic [4:0]     addrRdEx,
    output logic [4:0]     wbAddrEx,
    output logic           excRiEx
);

    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [31:0] rdata1;
    logic [31:0] rdata2;

    regFile u_regFile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wen    (wbEn),
        .waddr  (wbAddr),
        .wdata  (wbData)
    );

    idStage u_idStage (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .clr        (clr),
        .code       (code),
        .pc         (pc),
        .fwdAddrEx  (fwdAddrEx),
        .fwdAddrMem (fwdAddrMem),
        .fwdDataEx  (fwdDataEx),
        .fwdDataMem (fwdDataMem),
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .instr      (instr),
        .cmp        (cmp),
        .jumpTarget (jumpTarget),
        .jumpReg    (jumpReg),
        .instrEx    (instrEx),
        .pcEx       (pcEx),
        .dataRsEx   (dataRsEx),
        .dataRtEx   (dataRtEx),
        .wbDataEx   (wbDataEx),
        .imm16Ex    (imm16Ex),
        .shamtEx    (shamtEx),
        .addrRsEx   (addrRsEx),
        .addrRtEx   (addrRtEx),
        .addrRdEx   (addrRdEx),
        .wbAddrEx   (wbAddrEx),
        .excRiEx    (excRiEx)
    );

endmodule

//--- idTop_checker.sv
`timescale 1ns/100ps

module idTop_checker (
    input logic           clk,
    input logic           rst,
    input logic           stall,
    input logic           clr,
    input mipsPkg::instrT instrEx,
    input logic [31:0]    pcEx,
    input logic [31:0]    dataRsEx,
    input logic [31:0]    wbDataEx,
    input logic [4:0]     wbAddrEx
);
    import mipsPkg::*;

    // Failure count, watched by the testbench
    int violations = 0;

    // Reset and flush leave a bubble in the execute register
    clearGivesBubble: assert property (@(posedge clk)
        (rst || clr) |=> (instrEx == NOP && wbAddrEx == 5'd0))
        else begin
            $error("Execute register not cleared after reset or flush");
            violations++;
        end

    // A stalled stage keeps its execute outputs
    stallHolds: assert property (@(posedge clk)
        (stall && !rst && !clr) |=> ($stable(instrEx) && $stable(pcEx) &&
                                     $stable(dataRsEx) && $stable(wbDataEx)))
        else begin
            $error("Execute outputs changed during stall");
            violations++;
        end

    noDataWithoutTarget: assert property (@(posedge clk)
        (wbAddrEx == 5'd0) |-> (wbDataEx == 32'd0))
        else begin
            $error("Write-back data present with register zero as target");
            violations++;
        end

endmodule

//--- idTop_tb.sv
`timescale 1ns/100ps

module idTop_tb;
    import mipsPkg::*;

    localparam int CLK_PERIOD = 8;

    typedef struct {
        codeWordT    code;
        logic [31:0] pc;
        logic [4:0]  fwdAddrEx;
        logic [31:0] fwdDataEx;
        logic [4:0]  fwdAddrMem;
        logic [31:0] fwdDataMem;
        logic        stall;
        logic        clr;
        logic        wbEn;
        logic [4:0]  wbAddr;
        logic [31:0] wbData;
        instrT       expInstr;
        logic        expCmp;
        logic [4:0]  expWbAddr;
        logic        expExcRi;
    } rowT;

    // Expected content of the decode-to-execute register
    typedef struct packed {
        instrT       instr;
        logic [31:0] pc;
        logic [31:0] rsData;
        logic [31:0] rtData;
        logic [31:0] wbData;
        logic [15:0] imm16;
        logic [4:0]  shamt;
        logic [4:0]  addrRs;
        logic [4:0]  addrRt;
        logic [4:0]  addrRd;
        logic [4:0]  wbAddr;
        logic        excRi;
    } exT;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        clr;
    logic [31:0] code;
    logic [31:0] pc;
    logic [4:0]  fwdAddrEx;
    logic [31:0] fwdDataEx;
    logic [4:0]  fwdAddrMem;
    logic [31:0] fwdDataMem;
    logic        wbEn;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    instrT       instr;
    logic        cmp;
    logic [25:0] jumpTarget;
    logic [31:0] jumpReg;
    instrT       instrEx;
    logic [31:0] pcEx;
    logic [31:0] dataRsEx;
    logic [31:0] dataRtEx;
    logic [31:0] wbDataEx;
    logic [15:0] imm16Ex;
    logic [4:0]  shamtEx;
    logic [4:0]  addrRsEx;
    logic [4:0]  addrRtEx;
    logic [4:0]  addrRdEx;
    logic [4:0]  wbAddrEx;
    logic        excRiEx;

    rowT         rows[$];
    logic [31:0] model [NUM_REGS];
    logic [31:0] seed;
    logic [31:0] opRs;
    logic [31:0] opRt;
    exT          expEx;
    exT          pendEx;
    logic        prevStall;
    logic        prevClr;
    logic        tableReady = 1'b0;

    idTop i_dut (.*);

    bind idStage idTop_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic codeWordT rWord(input logic [5:0] op, input logic [4:0] s,
                                       input logic [4:0] t, input logic [4:0] d,
                                       input logic [4:0] sh, input logic [5:0] fn);
        codeWordT w;
        w.rFields.opcode = op;
        w.rFields.rs     = s;
        w.rFields.rt     = t;
        w.rFields.rd     = d;
        w.rFields.shamt  = sh;
        w.rFields.funct  = fn;
        return w;
    endfunction

    function automatic codeWordT iWord(input logic [5:0] op, input logic [4:0] s,
                                       input logic [4:0] t, input logic [15:0] imm);
        codeWordT w;
        w.ijFields.opcode = op;
        w.ijFields.rs     = s;
        w.ijFields.rt     = t;
        w.ijFields.imm16  = imm;
        return w;
    endfunction

    // Jump target overlays rs, rt and the immediate
    function automatic codeWordT jWord(input logic [5:0] op, input logic [25:0] target);
        codeWordT w;
        w.ijFields.opcode = op;
        {w.ijFields.rs, w.ijFields.rt, w.ijFields.imm16} = target;
        return w;
    endfunction

    task automatic addRow(input codeWordT c, input instrT expInstr, input logic expCmp,
                          input logic [4:0] expWbAddr, input logic expExcRi);
        rowT r;
        r.code       = c;
        r.pc         = 32'h0040_0000 + rows.size() * 4;
        r.fwdAddrEx  = 5'd0;
        r.fwdDataEx  = 32'd0;
        r.fwdAddrMem = 5'd0;
        r.fwdDataMem = 32'd0;
        r.stall      = 1'b0;
        r.clr        = 1'b0;
        r.wbEn       = 1'b0;
        r.wbAddr     = 5'd0;
        r.wbData     = 32'd0;
        r.expInstr   = expInstr;
        r.expCmp     = expCmp;
        r.expWbAddr  = expWbAddr;
        r.expExcRi   = expExcRi;
        rows.push_back(r);
    endtask

    task automatic setFwd(input logic [4:0] aEx, input logic [31:0] dEx,
                          input logic [4:0] aMem, input logic [31:0] dMem);
        int last;
        last = rows.size() - 1;
        rows[last].fwdAddrEx  = aEx;
        rows[last].fwdDataEx  = dEx;
        rows[last].fwdAddrMem = aMem;
        rows[last].fwdDataMem = dMem;
    endtask

    task automatic markStall();
        rows[rows.size() - 1].stall = 1'b1;
    endtask

    task automatic markClear();
        rows[rows.size() - 1].clr = 1'b1;
    endtask

    task automatic addWrite(input logic [4:0] a, input logic [31:0] d);
        int last;
        last = rows.size() - 1;
        rows[last].wbEn   = 1'b1;
        rows[last].wbAddr = a;
        rows[last].wbData = d;
    endtask

    task automatic buildTable();
        addRow(rWord(6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h20), ADD, 1'b0, 5'd3, 1'b0);
        addRow(iWord(6'h08, 5'd5, 5'd4, 16'h1234), ADDI, 1'b0, 5'd4, 1'b0);
        addRow(iWord(6'h23, 5'd6, 5'd7, 16'h0010), LW, 1'b0, 5'd7, 1'b0);
        addRow(iWord(6'h2b, 5'd6, 5'd7, 16'h0020), SW, 1'b0, 5'd0, 1'b0);
        addRow(jWord(6'h02, 26'h0123456), J, 1'b0, 5'd0, 1'b0);
        addRow(jWord(6'h03, 26'h0000040), JAL, 1'b0, LINK_REG, 1'b0);
        addRow(iWord(6'h0f, 5'd0, 5'd9, 16'hbeef), LUI, 1'b0, 5'd9, 1'b0);
        // Branch operands pinned through the forward pairs
        addRow(iWord(6'h01, 5'd10, 5'b00001, 16'h0004), BGEZ, 1'b1, 5'd0, 1'b0);
        setFwd(5'd10, 32'd0, 5'd0, 32'd0);
        addRow(iWord(6'h01, 5'd11, 5'b10001, 16'h0008), BGEZAL, 1'b1, LINK_REG, 1'b0);
        setFwd(5'd0, 32'd0, 5'd11, 32'h7fff_ffff);
        addRow(iWord(6'h01, 5'd12, 5'b10000, 16'h0008), BLTZAL, 1'b0, 5'd0, 1'b0);
        setFwd(5'd12, 32'd5, 5'd0, 32'd0);
        markStall();
        addRow(iWord(6'h01, 5'd13, 5'b00000, 16'hfffc), BLTZ, 1'b1, 5'd0, 1'b0);
        setFwd(5'd13, 32'h8000_0000, 5'd0, 32'd0);
        markStall();
        addRow(iWord(6'h07, 5'd14, 5'd0, 16'h0010), BGTZ, 1'b0, 5'd0, 1'b0);
        setFwd(5'd14, 32'd0, 5'd0, 32'd0);
        addRow(iWord(6'h06, 5'd15, 5'd0, 16'h0010), BLEZ, 1'b1, 5'd0, 1'b0);
        setFwd(5'd15, 32'hffff_ffff, 5'd0, 32'd0);
        addRow(iWord(6'h04, 5'd16, 5'd16, 16'h0002), BEQ, 1'b1, 5'd0, 1'b0);
        addRow(iWord(6'h05, 5'd16, 5'd17, 16'h0002), BNE, 1'b0, 5'd0, 1'b0);
        setFwd(5'd16, 32'h0000_0055, 5'd17, 32'h0000_0055);
        // Forwarding priority and the zero address
        addRow(rWord(6'h00, 5'd18, 5'd19, 5'd20, 5'd0, 6'h21), ADDU, 1'b0, 5'd20, 1'b0);
        setFwd(5'd18, 32'haaaa_0001, 5'd18, 32'hbbbb_0002);
        addRow(rWord(6'h00, 5'd0, 5'd0, 5'd21, 5'd0, 6'h25), OR, 1'b0, 5'd21, 1'b0);
        setFwd(5'd0, 32'hdead_0000, 5'd0, 32'hbeef_0000);
        markClear();
        addRow(rWord(6'h00, 5'd22, 5'd23, 5'd24, 5'd3, 6'h23), SUBU, 1'b0, 5'd24, 1'b0);
        setFwd(5'd5, 32'h1234_5678, 5'd22, 32'hcccc_0003);
        addRow(rWord(6'h00, 5'd25, 5'd26, 5'd27, 5'd0, 6'h0a), MOVZ, 1'b1, 5'd27, 1'b0);
        setFwd(5'd26, 32'd0, 5'd0, 32'd0);
        addRow(rWord(6'h00, 5'd25, 5'd26, 5'd27, 5'd0, 6'h0b), MOVN, 1'b0, 5'd0, 1'b0);
        setFwd(5'd26, 32'd0, 5'd0, 32'd0);
        // SPECIAL2, COP0 and a reserved opcode
        addRow(rWord(6'h1c, 5'd1, 5'd2, 5'd3, 5'd0, 6'h02), MUL, 1'b0, 5'd3, 1'b0);
        addRow(rWord(6'h10, 5'd0, 5'd8, 5'd12, 5'd0, 6'h00), MFC0, 1'b0, 5'd8, 1'b0);
        addRow(rWord(6'h10, 5'b10000, 5'd0, 5'd0, 5'd0, 6'h18), ERET, 1'b0, 5'd0, 1'b0);
        addRow(rWord(6'h3f, 5'd1, 5'd2, 5'd3, 5'd0, 6'h00), NOP, 1'b0, 5'd0, 1'b1);
        // Same-cycle write-back seen by the read, then by the array
        addRow(rWord(6'h00, 5'd5, 5'd0, 5'd0, 5'd0, 6'h08), JR, 1'b0, 5'd0, 1'b0);
        addWrite(5'd5, 32'hcafe_0005);
        addRow(rWord(6'h00, 5'd0, 5'd0, 5'd0, 5'd0, 6'h08), JR, 1'b0, 5'd0, 1'b0);
        addWrite(5'd0, 32'h1111_1111);
        addRow(rWord(6'h00, 5'd5, 5'd0, 5'd31, 5'd0, 6'h09), JALR, 1'b0, LINK_REG, 1'b0);
        addRow(32'd0, NOP, 1'b0, 5'd0, 1'b0);
    endtask

    // Execute pair first, then memory pair, then register file with bypass
    function automatic logic [31:0] expOperand(input int idx, input logic [4:0] addr);
        if (addr != 5'd0 && rows[idx].fwdAddrEx == addr) begin
            return rows[idx].fwdDataEx;
        end
        if (addr != 5'd0 && rows[idx].fwdAddrMem == addr) begin
            return rows[idx].fwdDataMem;
        end
        if (addr == 5'd0) begin
            return 32'd0;
        end
        if (rows[idx].wbEn && rows[idx].wbAddr == addr) begin
            return rows[idx].wbData;
        end
        return model[addr];
    endfunction

    function automatic logic [31:0] expWbData(input int idx, input logic [31:0] rsVal);
        if (rows[idx].expWbAddr == 5'd0) begin
            return 32'd0;
        end
        case (rows[idx].expInstr)
            MOVZ, MOVN:                return rsVal;
            JAL, JALR, BGEZAL, BLTZAL: return rows[idx].pc + PC_LINK_OFFSET;
            LUI:                       return {rows[idx].code.ijFields.imm16, 16'h0000};
            default:                   return 32'd0;
        endcase
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic driveRow(input int idx);
        code       <= rows[idx].code;
        pc         <= rows[idx].pc;
        fwdAddrEx  <= rows[idx].fwdAddrEx;
        fwdDataEx  <= rows[idx].fwdDataEx;
        fwdAddrMem <= rows[idx].fwdAddrMem;
        fwdDataMem <= rows[idx].fwdDataMem;
        stall      <= rows[idx].stall;
        clr        <= rows[idx].clr;
        wbEn       <= rows[idx].wbEn;
        wbAddr     <= rows[idx].wbAddr;
        wbData     <= rows[idx].wbData;
    endtask

    // Preload, rows and a margin of ten cycles
    initial begin
        wait (tableReady);
        #((31 + rows.size() + 10) * CLK_PERIOD);
        $display("Timeout: the test did not finish in the expected time");
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

    // A failed concurrent assertion ends the run at once
    initial begin
        wait (i_dut.u_idStage.u_checker.violations != 0);
        $display("Concurrent assertions in the checker reported a failure");
        $display("Result: FAILED");
        $fatal(1, "Checker assertion failed");
    end

    initial begin
        rst        = 1'b1;
        stall      = 1'b0;
        clr        = 1'b0;
        code       = 32'd0;
        pc         = 32'd0;
        fwdAddrEx  = 5'd0;
        fwdDataEx  = 32'd0;
        fwdAddrMem = 5'd0;
        fwdDataMem = 32'd0;
        wbEn       = 1'b0;
        wbAddr     = 5'd0;
        wbData     = 32'd0;
        expEx      = '0;
        pendEx     = '0;
        prevStall  = 1'b0;
        prevClr    = 1'b0;
        seed       = 32'd40;
        model[0]   = 32'd0;
        buildTable();
        tableReady = 1'b1;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkVal("instrEx", instrEx, NOP);
        checkVal("excRiEx", excRiEx, 1'b0);
        checkVal("wbAddrEx", wbAddrEx, 5'd0);

        for (int r = 1; r < NUM_REGS; r++) begin
            @(posedge clk);
            seed = xorshift(seed);
            wbEn     <= 1'b1;
            wbAddr   <= r[4:0];
            wbData   <= seed;
            model[r] = seed;
        end

        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            driveRow(i);
            @(negedge clk);
            opRs = expOperand(i, rows[i].code.rFields.rs);
            opRt = expOperand(i, rows[i].code.rFields.rt);
            checkVal("instr", instr, rows[i].expInstr);
            checkVal("cmp", cmp, rows[i].expCmp);
            checkVal("jumpReg", jumpReg, opRs);
            checkVal("jumpTarget", jumpTarget, rows[i].code[25:0]);

            // Previous row reaches the execute register at this edge
            if (prevClr) begin
                expEx = '0;
            end else if (!prevStall) begin
                expEx = pendEx;
            end
            checkVal("instrEx", instrEx, expEx.instr);
            checkVal("pcEx", pcEx, expEx.pc);
            checkVal("dataRsEx", dataRsEx, expEx.rsData);
            checkVal("dataRtEx", dataRtEx, expEx.rtData);
            checkVal("wbDataEx", wbDataEx, expEx.wbData);
            checkVal("imm16Ex", imm16Ex, expEx.imm16);
            checkVal("shamtEx", shamtEx, expEx.shamt);
            checkVal("addrRsEx", addrRsEx, expEx.addrRs);
            checkVal("addrRtEx", addrRtEx, expEx.addrRt);
            checkVal("addrRdEx", addrRdEx, expEx.addrRd);
            checkVal("wbAddrEx", wbAddrEx, expEx.wbAddr);
            checkVal("excRiEx", excRiEx, expEx.excRi);

            pendEx.instr  = rows[i].expInstr;
            pendEx.pc     = rows[i].pc;
            pendEx.rsData = opRs;
            pendEx.rtData = opRt;
            pendEx.wbData = expWbData(i, opRs);
            pendEx.imm16  = rows[i].code.ijFields.imm16;
            pendEx.shamt  = rows[i].code.rFields.shamt;
            pendEx.addrRs = rows[i].code.rFields.rs;
            pendEx.addrRt = rows[i].code.rFields.rt;
            pendEx.addrRd = rows[i].code.rFields.rd;
            pendEx.wbAddr = rows[i].expWbAddr;
            pendEx.excRi  = rows[i].expExcRi;
            prevStall     = rows[i].stall;
            prevClr       = rows[i].clr;
            if (rows[i].wbEn && rows[i].wbAddr != 5'd0) begin
                model[rows[i].wbAddr] = rows[i].wbData;
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
    input  mipsPkg::codeWordT   code,
    output mipsPkg::instrT      instr,
    output mipsPkg::instrClassT instrClass,
    output logic [4:0]          rs,
    output logic [4:0]          rt,
    output logic [4:0]          rd,
    output logic [4:0]          shamt,
    output logic [15:0]         imm16,
    output logic [25:0]         jumpTarget,
    output logic                excRi
);
    import mipsPkg::*;

    instrT decoded;
    logic  isZeroWord;

    // SPECIAL group, selected by funct
    function automatic instrT decodeSpecial(input logic [5:0] funct);
        case (funct)
            6'b100000: return ADD;
            6'b100010: return SUB;
            6'b100001: return ADDU;
            6'b100011: return SUBU;
            6'b100100: return AND;
            6'b100101: return OR;
            6'b100110: return XOR;
            6'b100111: return NOR;
            6'b101010: return SLT;
            6'b101011: return SLTU;
            6'b000000: return SLL;
            6'b000100: return SLLV;
            6'b000010: return SRL;
            6'b000110: return SRLV;
            6'b000011: return SRA;
            6'b000111: return SRAV;
            6'b001000: return JR;
            6'b001001: return JALR;
            6'b001010: return MOVZ;
            6'b001011: return MOVN;
            6'b001100: return SYSCALL;
            6'b001101: return BREAK;
            6'b011000: return MULT;
            6'b011001: return MULTU;
            6'b011010: return DIV;
            6'b011011: return DIVU;
            6'b010000: return MFHI;
            6'b010010: return MFLO;
            6'b010001: return MTHI;
            6'b010011: return MTLO;
            default:   return NOP;
        endcase
    endfunction

    // Plain I and J formats, selected by opcode
    function automatic instrT decodePrimary(input logic [5:0] opcode);
        case (opcode)
            6'b001000: return ADDI;
            6'b001001: return ADDIU;
            6'b001100: return ANDI;
            6'b001101: return ORI;
            6'b001110: return XORI;
            6'b001111: return LUI;
            6'b001010: return SLTI;
            6'b001011: return SLTIU;
            6'b100011: return LW;
            6'b100001: return LH;
            6'b100101: return LHU;
            6'b100000: return LB;
            6'b100100: return LBU;
            6'b101011: return SW;
            6'b101001: return SH;
            6'b101000: return SB;
            6'b000100: return BEQ;
            6'b000101: return BNE;
            6'b000110: return BLEZ;
            6'b000111: return BGTZ;
            6'b000010: return J;
            6'b000011: return JAL;
            default:   return NOP;
        endcase
    endfunction

    // REGIMM branches use rt as a sub-opcode
    function automatic instrT decodeRegimm(input logic [4:0] sel);
        case (sel)
            5'b00001: return BGEZ;
            5'b00000: return BLTZ;
            5'b10001: return BGEZAL;
            5'b10000: return BLTZAL;
            default:  return NOP;
        endcase
    endfunction

    function automatic instrT decodeSpecial2(input logic [5:0] funct);
        case (funct)
            6'b000000: return MADD;
            6'b000001: return MADDU;
            6'b000010: return MUL;
            6'b000100: return MSUB;
            6'b000101: return MSUBU;
            6'b100000: return CLZ;
            6'b100001: return CLO;
            default:   return NOP;
        endcase
    endfunction

    // COP0 moves by rs, eret needs the CO bit plus funct
    function automatic instrT decodeCop0(input logic [4:0] sel, input logic [5:0] funct);
        if (sel == 5'b00000) begin
            return MFC0;
        end else if (sel == 5'b00100) begin
            return MTC0;
        end else if (sel[4] && funct == 6'b011000) begin
            return ERET;
        end
        return NOP;
    endfunction

    function automatic instrClassT classOf(input instrT sym);
        case (sym)
            ADD, SUB, ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
            SLL, SLLV, SRL, SRLV, SRA, SRAV, MOVZ, MOVN, CLO, CLZ, MUL:
                return CALC_R;
            ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU:
                return CALC_I;
            LW, LH, LHU, LB, LBU:
                return MEM_READ;
            SW, SH, SB:
                return MEM_WRITE;
            BEQ, BNE, BLEZ, BGTZ, BGEZ, BLTZ, BGEZAL, BLTZAL:
                return BRANCH;
            J, JAL, JR, JALR:
                return JUMP;
            MULT, MULTU, DIV, DIVU, MADD, MADDU, MSUB, MSUBU,
            MFHI, MFLO, MTHI, MTLO:
                return MULTDIV;
            default:
                return OTHER;
        endcase
    endfunction

    assign rs         = code.rFields.rs;
    assign rt         = code.rFields.rt;
    assign rd         = code.rFields.rd;
    assign shamt      = code.rFields.shamt;
    assign imm16      = code.ijFields.imm16;
    assign jumpTarget = {code.ijFields.rs, code.ijFields.rt, code.ijFields.imm16};

    always_comb begin
        case (code.rFields.opcode)
            OP_SPECIAL:  decoded = decodeSpecial(code.rFields.funct);
            OP_REGIMM:   decoded = decodeRegimm(code.rFields.rt);
            OP_SPECIAL2: decoded = decodeSpecial2(code.rFields.funct);
            OP_COP0:     decoded = decodeCop0(code.rFields.rs, code.rFields.funct);
            default:     decoded = decodePrimary(code.rFields.opcode);
        endcase
    end

    // The all-zero word would otherwise decode as sll
    assign isZeroWord = (code == 32'd0);
    assign instr      = isZeroWord ? NOP : decoded;
    assign instrClass = classOf(instr);
    assign excRi      = !isZeroWord && (decoded == NOP);

endmodule

//--- mipsPkg.sv
package mipsPkg;

    // Architectural constants
    localparam int          NUM_REGS       = 32;
    localparam logic [4:0]  LINK_REG       = 5'd31;
    localparam logic [31:0] PC_LINK_OFFSET = 32'd8;

    // Primary opcodes that need a second-level decode
    localparam logic [5:0] OP_SPECIAL  = 6'b000000;
    localparam logic [5:0] OP_REGIMM   = 6'b000001;
    localparam logic [5:0] OP_COP0     = 6'b010000;
    localparam logic [5:0] OP_SPECIAL2 = 6'b011100;

    // Every instruction the decode stage recognizes, NOP doubles as "unknown"
    typedef enum logic [6:0] {
        NOP = 7'd0,
        // Register arithmetic and logic
        ADD, SUB, ADDU, SUBU,
        AND, OR, XOR, NOR,
        SLT, SLTU,
        SLL, SLLV, SRL, SRLV, SRA, SRAV,
        MOVZ, MOVN,
        CLO, CLZ, MUL,
        // Jumps through a register
        JR, JALR,
        // HI/LO unit
        MULT, MULTU, DIV, DIVU,
        MADD, MADDU, MSUB, MSUBU,
        MFHI, MFLO, MTHI, MTLO,
        // Immediate arithmetic
        ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU,
        // Loads and stores
        LW, LH, LHU, LB, LBU,
        SW, SH, SB,
        // Branches
        BEQ, BNE, BLEZ, BGTZ,
        BGEZ, BLTZ, BGEZAL, BLTZAL,
        // Absolute jumps
        J, JAL,
        // System and coprocessor 0
        SYSCALL, BREAK,
        MFC0, MTC0, ERET
    } instrT;

    typedef enum logic [2:0] {
        CALC_R,
        CALC_I,
        MEM_READ,
        MEM_WRITE,
        BRANCH,
        JUMP,
        MULTDIV,
        OTHER
    } instrClassT;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFieldsT;

    // For J-format words the 26-bit target is {rs, rt, imm16}
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } ijFieldsT;

    typedef union packed {
        rFieldsT  rFields;
        ijFieldsT ijFields;
    } codeWordT;

endpackage

//--- regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);
    import mipsPkg::*;

    logic [31:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-back in the same cycle is visible to decode
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end else if (wen && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1 = readPort(raddr1);
    end

    always_comb begin
        rdata2 = readPort(raddr2);
    end

endmodule
